/* Makefile */
# Verilator flow for the interrupt controller and its testbench

TB_TOP := tb_plic_top

.PHONY: all lint sim clean

all: sim

# lint the RTL top level
lint:
	verilator --lint-only --timing -f plic_top.f --top-module plic_top

# build and run, pass only when the pass message shows up in the output
sim:
	verilator --binary --timing --assert -j 0 -f plic_top.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* design/plic_claim_complete_tracker.sv */
// claim and complete tracker of the interrupt controller
// turns target pulses into gateway strobes and keeps outstanding claims

`include "plic_macros.svh"

module plic_claim_complete_tracker (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // identifier each target currently offers
    input  plic_pkg::id_t         best_id_i [`PLIC_NUM_TARGETS],
    // claim and complete pulses of each target
    input  plic_pkg::target_req_t req_i [`PLIC_NUM_TARGETS],
    // strobes to the gateways
    output plic_pkg::gw_ctrl_t    gw_ctrl_o
);

    // outstanding claims, one bit per source for every target
    plic_pkg::src_vec_t claimed_q  [`PLIC_NUM_TARGETS];
    // registered strobes before the OR over targets
    plic_pkg::src_vec_t claim_q    [`PLIC_NUM_TARGETS];
    plic_pkg::src_vec_t complete_q [`PLIC_NUM_TARGETS];

    // identifier k maps to bit k-1, identifier 0 gives an empty vector
    function automatic plic_pkg::src_vec_t id_to_vec(input plic_pkg::id_t id);
        plic_pkg::src_vec_t vec;
        vec = '0;
        for (int k = 0; k < `PLIC_NUM_SOURCES; k++) begin
            vec[k] = (id == plic_pkg::id_t'(k + 1));
        end
        return vec;
    endfunction

    // --------------------
    // per-target control
    // --------------------

    for (genvar t = 0; t < `PLIC_NUM_TARGETS; t++) begin : g_target
        plic_pkg::src_vec_t claim_vec;
        plic_pkg::src_vec_t complete_vec;

        // claim goes to whatever the arbiter offers right now
        assign claim_vec    = id_to_vec(best_id_i[t]);
        // complete only counts for a source this target really holds
        assign complete_vec = id_to_vec(req_i[t].complete_id) & claimed_q[t];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                claimed_q[t]  <= '0;
                claim_q[t]    <= '0;
                complete_q[t] <= '0;
            end else if (req_i[t].claim) begin
                // claim wins over a complete in the same cycle
                // an offered id of 0 yields an empty vector, so nothing happens
                claim_q[t]    <= claim_vec;
                complete_q[t] <= '0;
                claimed_q[t]  <= claimed_q[t] | claim_vec;
            end else if (req_i[t].complete) begin
                claim_q[t]    <= '0;
                complete_q[t] <= complete_vec;
                claimed_q[t]  <= claimed_q[t] & ~complete_vec;
            end else begin
                // strobes last a single cycle
                claim_q[t]    <= '0;
                complete_q[t] <= '0;
            end
        end
    end

    // --------------------
    // merge over targets
    // --------------------

    always_comb begin
        gw_ctrl_o = '0;
        for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
            gw_ctrl_o.claim    = gw_ctrl_o.claim | claim_q[t];
            gw_ctrl_o.complete = gw_ctrl_o.complete | complete_q[t];
        end
    end

endmodule

/* design/plic_gateway.sv */
// interrupt gateway for one level-sensitive source
// keeps the pending and in-service bits of that source

module plic_gateway (
    input  logic clk_i,
    input  logic rst_ni,
    // source level
    input  logic irq_i,
    // strobes from the tracker
    input  logic claim_i,
    input  logic complete_i,
    // request towards the arbiters
    output logic pending_o
);

    // request waiting for a claim
    logic pending_q;
    // claimed by a target, no complete seen yet
    logic in_service_q;

    // --------------------
    // pending bit
    // --------------------

    // the level is sampled only while the source is idle,
    // so at most one request per source is in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (claim_i) begin
            // handed to a target, drop the request
            pending_q <= 1'b0;
        end else if (irq_i && !pending_q && !in_service_q) begin
            pending_q <= 1'b1;
        end
    end

    // --------------------
    // in-service bit
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_service_q <= 1'b0;
        end else if (claim_i) begin
            in_service_q <= 1'b1;
        end else if (complete_i) begin
            // source may be re-sampled from the next cycle on
            in_service_q <= 1'b0;
        end
    end

    assign pending_o = pending_q;

endmodule

/* design/plic_pkg.sv */
// shared types of the interrupt controller
// vector typedefs plus the config, request and gateway strobe structs

`include "plic_macros.svh"

package plic_pkg;

    // --------------------
    // plain vectors
    // --------------------

    // priority 0 means the source never interrupts
    typedef logic [`PLIC_PRIO_BITS-1:0] prio_t;
    // source identifier, 0 is "no interrupt"
    typedef logic [`PLIC_ID_BITS-1:0] id_t;
    // one bit per source, bit 0 is identifier 1
    typedef logic [`PLIC_NUM_SOURCES-1:0] src_vec_t;

    // --------------------
    // grouped signals
    // --------------------

    // per-target configuration
    typedef struct packed {
        src_vec_t enable;
        prio_t    threshold;
    } target_cfg_t;

    // per-target claim and complete pulses
    typedef struct packed {
        logic claim;
        logic complete;
        id_t  complete_id;
    } target_req_t;

    // strobes from the tracker to the gateways, one bit per source
    typedef struct packed {
        src_vec_t claim;
        src_vec_t complete;
    } gw_ctrl_t;

endpackage

/* design/plic_target_arbiter.sv */
// per-target arbiter, purely combinational
// picks the best enabled pending source above the target threshold

`include "plic_macros.svh"

module plic_target_arbiter (
    // pending requests from all gateways
    input  plic_pkg::src_vec_t    pending_i,
    // priority of every source, index 0 is identifier 1
    input  plic_pkg::prio_t       prio_i [`PLIC_NUM_SOURCES],
    // enable mask and threshold of this target
    input  plic_pkg::target_cfg_t cfg_i,
    // interrupt line of the target
    output logic                  eip_o,
    // winning identifier, 0 when eip_o is low
    output plic_pkg::id_t         id_o
);

    // candidates after masking with the enables
    plic_pkg::src_vec_t eligible;
    // running best over the scan
    plic_pkg::prio_t    best_prio;
    plic_pkg::id_t      best_id;
    // best priority clears the threshold
    logic               above_thr;

    // --------------------
    // masking
    // --------------------

    assign eligible = pending_i & cfg_i.enable;

    // --------------------
    // priority scan
    // --------------------

    // scan from identifier 1 upwards
    // strict compare keeps the lower id on a tie,
    // and a priority of 0 can never win since best starts at 0
    always_comb begin
        best_prio = '0;
        best_id   = '0;
        for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
            if (eligible[i] && (prio_i[i] > best_prio)) begin
                best_prio = prio_i[i];
                best_id   = plic_pkg::id_t'(i + 1);
            end
        end
    end

    // --------------------
    // outputs
    // --------------------

    // threshold is exclusive, equal priority is masked
    assign above_thr = best_prio > cfg_i.threshold;

    assign eip_o = above_thr;

    // nothing offered unless the line is raised
    always_comb begin
        if (above_thr) begin
            id_o = best_id;
        end else begin
            id_o = '0;
        end
    end

endmodule

/* design/plic_top.sv */
// top level of the interrupt controller
// gateways per source, arbiters per target and the claim/complete tracker

`include "plic_macros.svh"

module plic_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // level interrupt inputs, bit 0 is identifier 1
    input  plic_pkg::src_vec_t    irq_sources_i,
    // configuration, held static by the system
    input  plic_pkg::prio_t       src_prio_i   [`PLIC_NUM_SOURCES],
    input  plic_pkg::target_cfg_t target_cfg_i [`PLIC_NUM_TARGETS],
    // claim and complete pulses from the targets
    input  plic_pkg::target_req_t target_req_i [`PLIC_NUM_TARGETS],
    // interrupt line and offered identifier per target
    output logic [`PLIC_NUM_TARGETS-1:0] eip_o,
    output plic_pkg::id_t         claim_id_o   [`PLIC_NUM_TARGETS]
);

    // requests from all gateways
    plic_pkg::src_vec_t pending;
    // strobes from the tracker
    plic_pkg::gw_ctrl_t gw_ctrl;

    // --------------------
    // gateways
    // --------------------

    for (genvar s = 0; s < `PLIC_NUM_SOURCES; s++) begin : g_gateway
        plic_gateway i_gateway (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .irq_i      (irq_sources_i[s]),
            .claim_i    (gw_ctrl.claim[s]),
            .complete_i (gw_ctrl.complete[s]),
            .pending_o  (pending[s])
        );
    end

    // --------------------
    // arbiters
    // --------------------

    for (genvar t = 0; t < `PLIC_NUM_TARGETS; t++) begin : g_arbiter
        plic_target_arbiter i_arbiter (
            .pending_i (pending),
            .prio_i    (src_prio_i),
            .cfg_i     (target_cfg_i[t]),
            .eip_o     (eip_o[t]),
            .id_o      (claim_id_o[t])
        );
    end

    // claims pick up the identifier each arbiter offers
    plic_claim_complete_tracker i_tracker (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .best_id_i (claim_id_o),
        .req_i     (target_req_i),
        .gw_ctrl_o (gw_ctrl)
    );

endmodule

/* include/plic_macros.svh */
// size parameters of the interrupt controller
// source count, target count, priority width and identifier width

`ifndef PLIC_MACROS_SVH
`define PLIC_MACROS_SVH

// number of interrupt sources, identifiers 1..NUM_SOURCES
`define PLIC_NUM_SOURCES 7

// number of targets (hart contexts)
`define PLIC_NUM_TARGETS 2

// width of a source priority and a target threshold
`define PLIC_PRIO_BITS 3

// must hold NUM_SOURCES since identifier 0 is reserved for "none"
`define PLIC_ID_BITS 3

`endif

/* plic_top.f */
+incdir+include
design/plic_pkg.sv
design/plic_gateway.sv
design/plic_target_arbiter.sv
design/plic_claim_complete_tracker.sv
design/plic_top.sv
tests/tb_clock.sv
tests/tb_plic_top.sv

/* tests/tb_clock.sv */
// clock and reset source of the testbench
// 10 ns clock, reset low for the first 3 rising edges

module tb_clock (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* tests/tb_plic_top.sv */
// testbench of the interrupt controller
// directed and random stimulus, cycle-level reference model, checks and watchdog

`include "plic_macros.svh"

module tb_plic_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_src = `PLIC_NUM_SOURCES;
    localparam int num_tgt = `PLIC_NUM_TARGETS;
    localparam int directed_cycles = 120;
    localparam int rand_cycles = 500;
    // reset, directed part, random part and the drain at the end
    localparam int test_cycles = 3 + directed_cycles + rand_cycles + 10;

    logic clk;
    logic rst_n;
    plic_pkg::src_vec_t    irq_sources;
    plic_pkg::prio_t       src_prio   [num_src];
    plic_pkg::target_cfg_t target_cfg [num_tgt];
    plic_pkg::target_req_t target_req [num_tgt];
    logic [num_tgt-1:0]    eip;
    plic_pkg::id_t         claim_id   [num_tgt];

    // --------------------
    // reference model state
    // --------------------
    plic_pkg::src_vec_t m_pending;
    plic_pkg::src_vec_t m_in_service;
    // outstanding claims and registered strobes of each target
    plic_pkg::src_vec_t m_claimed    [num_tgt];
    plic_pkg::src_vec_t m_claim_q    [num_tgt];
    plic_pkg::src_vec_t m_complete_q [num_tgt];

    int errors;
    int checks;
    int seed;

    tb_clock i_clock (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    plic_top i_plic_top (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .irq_sources_i (irq_sources),
        .src_prio_i    (src_prio),
        .target_cfg_i  (target_cfg),
        .target_req_i  (target_req),
        .eip_o         (eip),
        .claim_id_o    (claim_id)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // identifier k sets bit k-1, identifier 0 sets nothing
    function automatic plic_pkg::src_vec_t id_bit(input plic_pkg::id_t id);
        if (id == '0) begin
            return '0;
        end
        return plic_pkg::src_vec_t'(1) << (id - 1);
    endfunction

    // expected offer of target t
    // eip is expected high exactly when this is not 0
    function automatic plic_pkg::id_t best_id(input int t);
        plic_pkg::prio_t top_prio;
        plic_pkg::id_t   id;
        top_prio = '0;
        id = '0;
        // lower ids are seen first and keep the slot on a tie
        for (int s = 0; s < num_src; s++) begin
            if (m_pending[s] && target_cfg[t].enable[s] && src_prio[s] > top_prio) begin
                top_prio = src_prio[s];
                id = plic_pkg::id_t'(s + 1);
            end
        end
        if (top_prio <= target_cfg[t].threshold) begin
            id = '0;
        end
        return id;
    endfunction

    // --------------------
    // compare, then step the model
    // --------------------
    always @(posedge clk) begin : check_and_model
        plic_pkg::id_t      exp_id [num_tgt];
        plic_pkg::src_vec_t clm;
        plic_pkg::src_vec_t cmp;
        if (!rst_n) begin
            m_pending = '0;
            m_in_service = '0;
            for (int t = 0; t < num_tgt; t++) begin
                m_claimed[t] = '0;
                m_claim_q[t] = '0;
                m_complete_q[t] = '0;
            end
        end else begin
            for (int t = 0; t < num_tgt; t++) begin
                exp_id[t] = best_id(t);
                checks++;
                assert (claim_id[t] == exp_id[t]) else begin
                    $display("FAIL %0t claim_id_o[%0d] expected %0d actual %0d",
                             $time, t, exp_id[t], claim_id[t]);
                    errors++;
                end
                assert (eip[t] == (exp_id[t] != '0)) else begin
                    $display("FAIL %0t eip_o[%0d] expected %0b actual %0b",
                             $time, t, exp_id[t] != '0, eip[t]);
                    errors++;
                end
            end
            // gateways act on the strobes registered one edge earlier
            clm = '0;
            cmp = '0;
            for (int t = 0; t < num_tgt; t++) begin
                clm = clm | m_claim_q[t];
                cmp = cmp | m_complete_q[t];
            end
            for (int s = 0; s < num_src; s++) begin
                if (clm[s]) begin
                    m_pending[s] = 1'b0;
                    m_in_service[s] = 1'b1;
                end else begin
                    // level is only taken while the source is idle
                    if (irq_sources[s] && !m_pending[s] && !m_in_service[s]) begin
                        m_pending[s] = 1'b1;
                    end
                    if (cmp[s]) begin
                        m_in_service[s] = 1'b0;
                    end
                end
            end
            // tracker step where a claim beats a complete from the same target
            for (int t = 0; t < num_tgt; t++) begin
                m_claim_q[t] = '0;
                m_complete_q[t] = '0;
                if (target_req[t].claim) begin
                    m_claim_q[t] = id_bit(exp_id[t]);
                    m_claimed[t] = m_claimed[t] | m_claim_q[t];
                end else if (target_req[t].complete) begin
                    m_complete_q[t] = id_bit(target_req[t].complete_id) & m_claimed[t];
                    m_claimed[t] = m_claimed[t] & ~m_complete_q[t];
                end
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_claim(input int t);
        @(negedge clk);
        target_req[t].claim = 1'b1;
        @(negedge clk);
        target_req[t].claim = 1'b0;
    endtask

    task automatic pulse_complete(input int t, input plic_pkg::id_t id);
        @(negedge clk);
        target_req[t].complete = 1'b1;
        target_req[t].complete_id = id;
        @(negedge clk);
        target_req[t].complete = 1'b0;
    endtask

    // thresholds kept in 0..3 so that enough sources get through
    task automatic random_config();
        logic [31:0] r;
        for (int s = 0; s < num_src; s++) begin
            r = next_random();
            src_prio[s] = r[`PLIC_PRIO_BITS-1:0];
        end
        for (int t = 0; t < num_tgt; t++) begin
            r = next_random();
            target_cfg[t].enable = r[num_src-1:0];
            target_cfg[t].threshold = plic_pkg::prio_t'(r[num_src+1:num_src]);
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 32'h6847eb7d;
        errors = 0;
        checks = 0;
        irq_sources = '0;
        for (int s = 0; s < num_src; s++) begin
            src_prio[s] = '0;
        end
        for (int t = 0; t < num_tgt; t++) begin
            target_cfg[t] = '0;
            target_req[t] = '0;
        end
        @(posedge rst_n);
        // quiet after reset with all sources low
        idle_cycles(5);
        // src 2 and 3 tie at 5, src 4 has priority 0, src 6 disabled for target 0
        src_prio[0] = 3'd3;
        src_prio[1] = 3'd5;
        src_prio[2] = 3'd5;
        src_prio[3] = 3'd0;
        src_prio[4] = 3'd2;
        src_prio[5] = 3'd7;
        src_prio[6] = 3'd1;
        target_cfg[0].enable = 7'b101_1111;
        target_cfg[0].threshold = 3'd1;
        target_cfg[1].enable = 7'b111_0000;
        target_cfg[1].threshold = 3'd2;
        irq_sources = 7'b101_1111;
        idle_cycles(4);
        // target 1 sees nothing above its threshold, so this claim is dropped
        pulse_claim(1);
        idle_cycles(3);
        pulse_claim(0);
        idle_cycles(5);
        pulse_claim(0);
        idle_cycles(5);
        irq_sources[5] = 1'b1;
        idle_cycles(3);
        pulse_claim(1);
        idle_cycles(4);
        // completes for sources that are in service under another owner
        // id 3 never claimed by target 1, id 2 held by target 0, id 6 held by target 1
        pulse_complete(1, 3'd3);
        pulse_complete(1, 3'd2);
        pulse_complete(0, 3'd6);
        idle_cycles(5);
        pulse_complete(0, 3'd2);
        idle_cycles(6);
        pulse_complete(1, 3'd6);
        idle_cycles(6);
        // claim and complete together from target 0
        @(negedge clk);
        target_req[0] = '{claim: 1'b1, complete: 1'b1, complete_id: 3'd3};
        @(negedge clk);
        target_req[0] = '0;
        idle_cycles(5);
        irq_sources = '0;
        idle_cycles(10);
        // random part
        for (int i = 0; i < rand_cycles; i++) begin
            @(negedge clk);
            if (i % 50 == 0) begin
                random_config();
            end
            r = next_random();
            irq_sources = r[num_src-1:0];
            for (int t = 0; t < num_tgt; t++) begin
                r = next_random();
                target_req[t].claim = r[0] & r[1];
                target_req[t].complete = r[2] & r[3];
                target_req[t].complete_id = r[`PLIC_ID_BITS+5:6];
            end
        end
        @(negedge clk);
        for (int t = 0; t < num_tgt; t++) begin
            target_req[t] = '0;
        end
        idle_cycles(10);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(test_cycles * 10 + 500);
        $display("timeout, the stimulus did not reach its end in time");
        $display("Test failed");
        $finish;
    end

endmodule
